// ==== all.f ====
+incdir+include
source/ex_types_pkg.sv
source/ex_ctrl_pkg.sv
source/ex_operand_sel.sv
source/ex_alu.sv
source/ex_shift_xchg.sv
source/ex_result_sel.sv
source/ex_wb_ctrl.sv
source/ex_wb_latch.sv
source/ex_stage.sv
tb/tb_clkgen.sv
tb/tb_ex_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_ex_stage -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_ex_stage)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
exit 1

// ==== tb/tb_ex_stage.sv ====
/*
 * execute stage testbench
 * directed and random micro-ops, one-deep reference model,
 * concurrent assertions compare wb against the model
 */
`timescale 1ns/100ps
`include "ex_consts.svh"

module tb_ex_stage
	import ex_types_pkg::*;
	import ex_ctrl_pkg::*;
();

	localparam int clk_period = 40;
	localparam int reset_cycles = 2;
	localparam int n_random = 200;
	localparam int directed_max = 40;
	// reset, directed, random, plus drain and slack
	localparam int watchdog_cycles = reset_cycles + directed_max + n_random + 18;

	logic clk;
	logic rst_n;
	logic ex_v;
	ex_ctrl_t ctrl;
	ex_opnd_t opnd;
	ex_wb_t wb;

	// model state
	ex_wb_t exp_next;
	ex_wb_t exp_wb;
	word_t held_m;

	int seed = 14;
	int errors = 0;
	int uops = 0;

	tb_clkgen #(.period(clk_period), .reset_cycles(reset_cycles)) u_clkgen (
		.clk(clk), .rst_n(rst_n));

	ex_stage u_dut (.clk(clk), .rst_n(rst_n), .ex_v(ex_v), .ctrl(ctrl), .opnd(opnd), .wb(wb));

	task automatic report_error(input string msg);
		errors++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic ex_wb_t predict(input logic v, input ex_ctrl_t c, input ex_opnd_t o,
			input word_t held);
		ex_wb_t w;
		word_t b;
		word_t r;
		word_t pop;
		mm_t hi;
		logic cf;
		logic of;
		logic zf;
		longint s;
		int n;
		w = '0;
		r = '0;
		cf = 1'b0;
		of = 1'b0;
		b = c.is_cmps_second ? held : o.b;
		// shifter always sees the raw B
		n = int'(o.b[4:0]);
		if (c.use_shift) begin
			case (c.shift_op)
				sh_shl: begin
					r = o.a << n;
					cf = (n == 0) ? 1'b0 : o.a[`EX_DATA_W - n];
				end
				sh_shr: begin
					r = o.a >> n;
					cf = (n == 0) ? 1'b0 : o.a[n - 1];
				end
				sh_sar: begin
					r = $signed(o.a) >>> n;
					cf = (n == 0) ? 1'b0 : o.a[n - 1];
				end
				default: r = o.b;
			endcase
		end else begin
			case (c.alu_op)
				alu_add: begin
					r = o.a + b;
					// wrapped sum is below an addend
					cf = r < o.a;
					s = longint'($signed(o.a)) + longint'($signed(b));
					of = s != longint'($signed(r));
				end
				alu_sub: begin
					r = o.a - b;
					cf = o.a < b;
					s = longint'($signed(o.a)) - longint'($signed(b));
					of = s != longint'($signed(r));
				end
				alu_and: r = o.a & b;
				alu_or: r = o.a | b;
				alu_xor: r = o.a ^ b;
				default: r = b;
			endcase
		end
		// xchg path reports no flags
		if (!(c.use_shift && c.shift_op == sh_xchg)) begin
			w.flags[`EX_ZF] = (r == '0);
			w.flags[`EX_SF] = r[`EX_DATA_W-1];
			w.flags[`EX_CF] = cf;
			w.flags[`EX_OF] = of;
		end
		zf = w.flags[`EX_ZF];
		if (c.is_cmps_first || c.is_xchg) begin
			w.result_a = b;
		end else if (c.pass_a) begin
			w.result_a = o.a;
		end else if (c.is_cmpxchg) begin
			w.result_a = o.c;
		end else begin
			w.result_a = r;
		end
		w.result_b = (c.is_cmpxchg || c.is_xchg) ? o.a : b;
		pop = c.dsize[1] ? word_t'(`EX_POP_INC_D) : word_t'(`EX_POP_INC_W);
		w.result_c = c.sp_pop ? o.c + pop : o.c;
		// lane msbs added apart so no carry crosses into the next lane
		hi = {4{16'h8000}};
		w.result_mm = ((o.mm_a & ~hi) + (o.mm_b & ~hi)) ^ ((o.mm_a ^ o.mm_b) & hi);
		// cmpxchg equal stores and unequal reloads the accumulator
		w.ld_gpr1 = v && c.ld_gpr1 && (!c.is_cmpxchg || zf);
		w.ld_gpr2 = v && (c.is_cmpxchg ? !zf : c.ld_gpr2);
		w.ld_gpr3 = v && c.ld_gpr3;
		w.ld_seg = v && c.ld_seg;
		w.ld_mm = v && c.ld_mm;
		w.dcache_write = v && c.dcache_write && (!c.is_cmpxchg || zf);
		return w;
	endfunction

	always_comb exp_next = predict(ex_v, ctrl, opnd, held_m);

	// one-deep model register plus its own cmps hold
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exp_wb <= '0;
			held_m <= '0;
		end else begin
			exp_wb <= exp_next;
			if (ex_v && ctrl.is_cmps_first) begin
				held_m <= opnd.a;
			end
		end
	end

	// ------------------------------
	// checks
	// ------------------------------
	a_results : assert property (@(posedge clk) disable iff (!rst_n)
		wb.result_a == exp_wb.result_a && wb.result_b == exp_wb.result_b &&
		wb.result_c == exp_wb.result_c)
		else report_error("result a/b/c differs from model");

	a_flags : assert property (@(posedge clk) disable iff (!rst_n)
		wb.flags == exp_wb.flags)
		else report_error("flags differ from model");

	a_mm : assert property (@(posedge clk) disable iff (!rst_n)
		wb.result_mm == exp_wb.result_mm)
		else report_error("mm lane sums differ from model");

	a_enables : assert property (@(posedge clk) disable iff (!rst_n)
		{wb.ld_gpr1, wb.ld_gpr2, wb.ld_gpr3, wb.ld_seg, wb.ld_mm, wb.dcache_write} ==
		{exp_wb.ld_gpr1, exp_wb.ld_gpr2, exp_wb.ld_gpr3, exp_wb.ld_seg, exp_wb.ld_mm,
		exp_wb.dcache_write})
		else report_error("write enables differ from model");

	// bubble in means no writes out
	a_idle_quiet : assert property (@(posedge clk) disable iff (!rst_n)
		!$past(ex_v) |-> !(wb.ld_gpr1 || wb.ld_gpr2 || wb.ld_gpr3 || wb.ld_seg ||
		wb.ld_mm || wb.dcache_write))
		else report_error("write enable set after an invalid cycle");

	a_reset_clear : assert property (@(posedge clk) disable iff (!rst_n)
		!$past(rst_n) |-> wb == '0)
		else report_error("wb not cleared by reset");

	a_cmpxchg_excl : assert property (@(posedge clk) disable iff (!rst_n)
		$past(ex_v && ctrl.is_cmpxchg) |-> !(wb.ld_gpr1 && wb.ld_gpr2))
		else report_error("cmpxchg wrote both gpr1 and gpr2");

	// ------------------------------
	// stimulus
	// ------------------------------
	task automatic drive(input logic v, input ex_ctrl_t c, input ex_opnd_t o);
		@(posedge clk);
		#2;
		ex_v = v;
		ctrl = c;
		opnd = o;
		if (v) begin
			uops++;
		end
	endtask

	initial begin
		ex_ctrl_t c;
		ex_opnd_t o;
		word_t r;
		ex_v = 1'b0;
		ctrl = '0;
		opnd = '0;
		wait (rst_n);

		// bubbles with every write requested
		c = '0;
		{c.ld_gpr1, c.ld_gpr2, c.ld_gpr3, c.ld_seg, c.ld_mm, c.dcache_write} = 6'h3f;
		o = '0;
		drive(1'b0, c, o);
		drive(1'b0, c, o);

		// alu ops with overflow and carry corners
		c.ld_gpr2 = 1'b0;
		o.mm_a = {4{16'hffff}};
		o.mm_b = 64'h0001_0002_0003_8000;
		for (int i = 0; i < 6; i++) begin
			c.alu_op = alu_op_e'(3'(i));
			o.a = 32'h7fff_ffff;
			o.b = 32'h0000_0001;
			drive(1'b1, c, o);
			o.a = 32'h8000_0000;
			o.b = 32'h8000_0000;
			drive(1'b1, c, o);
		end

		// shifter amount above 31 wraps to its low bits
		c.use_shift = 1'b1;
		for (int i = 0; i < 4; i++) begin
			c.shift_op = shift_op_e'(2'(i));
			o.a = 32'h8000_0001;
			o.b = 32'h0000_0021;
			drive(1'b1, c, o);
			o.a = 32'hf000_0000;
			o.b = 32'h0000_0004;
			drive(1'b1, c, o);
		end

		// cmps pairs equal then unequal
		c = '0;
		c.alu_op = alu_sub;
		c.ld_gpr1 = 1'b1;
		o = '0;
		o.a = 32'h1234_5678;
		o.b = 32'h0bad_cafe;
		for (int i = 0; i < 2; i++) begin
			c.is_cmps_first = 1'b1;
			c.is_cmps_second = 1'b0;
			drive(1'b1, c, o);
			c.is_cmps_first = 1'b0;
			c.is_cmps_second = 1'b1;
			o.a = o.a + word_t'(i);
			drive(1'b1, c, o);
		end

		// cmpxchg hit then miss
		c = '0;
		c.alu_op = alu_sub;
		c.is_cmpxchg = 1'b1;
		c.ld_gpr1 = 1'b1;
		c.dcache_write = 1'b1;
		o.a = 32'h0000_0055;
		o.b = 32'h0000_0055;
		o.c = 32'h0000_c0de;
		drive(1'b1, c, o);
		o.b = 32'h0000_0056;
		drive(1'b1, c, o);

		// xchg swap
		c = '0;
		c.use_shift = 1'b1;
		c.shift_op = sh_xchg;
		c.is_xchg = 1'b1;
		c.ld_gpr1 = 1'b1;
		c.ld_gpr2 = 1'b1;
		drive(1'b1, c, o);

		// pop dword, pop word, no pop; esp wraps
		c = '0;
		c.alu_op = alu_pass_b;
		c.sp_pop = 1'b1;
		c.ld_gpr3 = 1'b1;
		c.dsize = 2'b10;
		o.c = 32'hffff_fffe;
		drive(1'b1, c, o);
		c.dsize = 2'b01;
		drive(1'b1, c, o);
		c.sp_pop = 1'b0;
		drive(1'b1, c, o);

		// random micro-ops with about one bubble in four
		for (int k = 0; k < n_random; k++) begin
			r = $random(seed);
			c = '0;
			c.alu_op = alu_op_e'(3'(r[7:4] % 6));
			c.shift_op = shift_op_e'(r[9:8]);
			c.use_shift = r[10];
			c.pass_a = r[11] & r[12];
			c.is_cmps_first = (r[14:13] == 2'd1);
			c.is_cmps_second = (r[14:13] == 2'd2);
			c.is_xchg = r[15] & r[16];
			c.is_cmpxchg = r[17] & r[18];
			c.sp_pop = r[19];
			c.dsize = r[21:20];
			{c.ld_gpr1, c.ld_gpr2, c.ld_gpr3, c.ld_seg, c.ld_mm, c.dcache_write} = r[27:22];
			o.a = $random(seed);
			// equal operands now and then to set ZF
			o.b = r[28] ? o.a : $random(seed);
			o.c = $random(seed);
			o.mm_a = {$random(seed), $random(seed)};
			o.mm_b = {$random(seed), $random(seed)};
			drive(r[31] | r[30], c, o);
		end

		// drain the last micro-op through wb
		c = '0;
		o = '0;
		drive(1'b0, c, o);
		repeat (2) @(posedge clk);
		#1;
		$display("checked uops: %0d, errors: %0d", uops, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(watchdog_cycles * clk_period);
		$display("timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== tb/tb_clkgen.sv ====
/*
 * testbench clock and reset
 * free running clock, rst_n held low for the first edges
 */
`timescale 1ns/100ps

module tb_clkgen #(
	parameter int period = 40,
	parameter int reset_cycles = 2
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// release just after an edge, away from sampling
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#2;
		rst_n = 1'b1;
	end

endmodule

// ==== source/ex_stage.sv ====
/*
 * execute stage top
 * operand select, ALU, shifter, result select, write control, EX/WB reg
 */
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_stage
	import ex_types_pkg::*;
	import ex_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic ex_v,
	input ex_ctrl_t ctrl,
	input ex_opnd_t opnd,
	output ex_wb_t wb
);

	word_t eff_b;
	word_t alu_result;
	flags_t alu_flags;
	mm_t alu_mm;
	word_t shift_result;
	flags_t shift_flags;
	// results only, then with qualified enables
	ex_wb_t wb_res;
	ex_wb_t wb_next;

	// ------------------------------
	// operands and function units
	// ------------------------------
	ex_operand_sel u_operand_sel (.clk(clk), .rst_n(rst_n), .ex_v(ex_v), .ctrl(ctrl),
		.a(opnd.a), .b(opnd.b), .eff_b(eff_b));

	ex_alu u_alu (.op(ctrl.alu_op), .a(opnd.a), .b(eff_b), .mm_a(opnd.mm_a),
		.mm_b(opnd.mm_b), .result(alu_result), .flags(alu_flags), .mm_result(alu_mm));

	ex_shift_xchg u_shift_xchg (.op(ctrl.shift_op), .a(opnd.a), .b(opnd.b),
		.result(shift_result), .flags(shift_flags));

	// ------------------------------
	// write-back path
	// ------------------------------
	ex_result_sel u_result_sel (.ctrl(ctrl), .opnd(opnd), .eff_b(eff_b),
		.alu_result(alu_result), .alu_flags(alu_flags), .alu_mm(alu_mm),
		.shift_result(shift_result), .shift_flags(shift_flags), .wb_next(wb_res));

	// cmpxchg decides on the selected ZF
	ex_wb_ctrl u_wb_ctrl (.ex_v(ex_v), .ctrl(ctrl), .zf(wb_res.flags[`EX_ZF]),
		.wb_in(wb_res), .wb_out(wb_next));

	ex_wb_latch u_wb_latch (.clk(clk), .rst_n(rst_n), .wb_next(wb_next), .wb(wb));

endmodule

// ==== source/ex_wb_latch.sv ====
/*
 * EX/WB pipeline register
 * one cycle, whole record cleared on reset
 */
`timescale 1ns/100ps

module ex_wb_latch
	import ex_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input ex_wb_t wb_next,
	output ex_wb_t wb
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb <= '0;
		end else begin
			wb <= wb_next;
		end
	end

endmodule

// ==== source/ex_wb_ctrl.sv ====
/*
 * EX write control
 * CMPXCHG outcome on the gpr / dcache writes, then valid qualify
 */
`timescale 1ns/100ps

module ex_wb_ctrl
	import ex_ctrl_pkg::*;
(
	input logic ex_v,
	input ex_ctrl_t ctrl,
	input logic zf,
	input ex_wb_t wb_in,
	output ex_wb_t wb_out
);

	logic gpr1;
	logic gpr2;
	logic dc_wr;

	// ------------------------------
	// cmpxchg decision
	// ------------------------------
	// equal: store to dest (gpr1 or memory)
	// not equal: load accumulator (gpr2)
	assign gpr1 = ctrl.is_cmpxchg ? (ctrl.ld_gpr1 & zf) : ctrl.ld_gpr1;
	assign gpr2 = ctrl.is_cmpxchg ? ~zf : ctrl.ld_gpr2;
	assign dc_wr = ctrl.is_cmpxchg ? (ctrl.dcache_write & zf) : ctrl.dcache_write;

	// results pass, every enable needs a valid uop
	always_comb begin
		wb_out = wb_in;
		wb_out.ld_gpr1 = ex_v & gpr1;
		wb_out.ld_gpr2 = ex_v & gpr2;
		wb_out.ld_gpr3 = ex_v & ctrl.ld_gpr3;
		wb_out.ld_seg = ex_v & ctrl.ld_seg;
		wb_out.ld_mm = ex_v & ctrl.ld_mm;
		wb_out.dcache_write = ex_v & dc_wr;
	end

endmodule

// ==== source/ex_result_sel.sv ====
/*
 * EX result select
 * picks result A/B/C and flags for write-back, incl. esp update on pop
 */
`timescale 1ns/100ps

module ex_result_sel
	import ex_types_pkg::*;
	import ex_ctrl_pkg::*;
(
	input ex_ctrl_t ctrl,
	input ex_opnd_t opnd,
	input word_t eff_b,
	input word_t alu_result,
	input flags_t alu_flags,
	input mm_t alu_mm,
	input word_t shift_result,
	input flags_t shift_flags,
	output ex_wb_t wb_next
);

	word_t fu_result;
	word_t pop_inc;

	// function unit result select
	assign fu_result = ctrl.use_shift ? shift_result : alu_result;

	// dword pop when dsize[1]
	assign pop_inc = ctrl.dsize[1] ? word_t'(`EX_POP_INC_D) : word_t'(`EX_POP_INC_W);

	always_comb begin
		// enables are filled in by the write control
		wb_next = '0;

		// ------------------------------
		// result A with highest priority first
		// ------------------------------
		if (ctrl.is_cmps_first || ctrl.is_xchg) begin
			wb_next.result_a = eff_b;
		end else if (ctrl.pass_a) begin
			wb_next.result_a = opnd.a;
		end else if (ctrl.is_cmpxchg) begin
			// cmpxchg stores C to the dest on a match
			wb_next.result_a = opnd.c;
		end else begin
			wb_next.result_a = fu_result;
		end

		// result B swaps in A for xchg and cmpxchg
		wb_next.result_b = (ctrl.is_cmpxchg || ctrl.is_xchg) ? opnd.a : eff_b;

		// result C carries esp
		wb_next.result_c = ctrl.sp_pop ? opnd.c + pop_inc : opnd.c;

		wb_next.flags = ctrl.use_shift ? shift_flags : alu_flags;
		wb_next.result_mm = alu_mm;
	end

endmodule

// ==== source/ex_shift_xchg.sv ====
/*
 * EX shifter
 * SHL / SHR / SAR of A by B[4:0], CF is the last bit out;
 * the XCHG path passes B through with clear flags
 */
`timescale 1ns/100ps

module ex_shift_xchg
	import ex_types_pkg::*;
(
	input shift_op_e op,
	input word_t a,
	input word_t b,
	output word_t result,
	output flags_t flags
);

	localparam int sh_w = $clog2(`EX_DATA_W);

	logic [sh_w-1:0] shamt;
	// one extra bit catches the last bit shifted out
	logic [`EX_DATA_W:0] wide;

	assign shamt = b[sh_w-1:0];

	always_comb begin
		wide = '0;
		result = '0;
		flags = '0;
		case (op)
			sh_shl: begin
				// carry lands above the msb
				wide = {1'b0, a} << shamt;
				result = wide[`EX_DATA_W-1:0];
				flags[`EX_CF] = wide[`EX_DATA_W];
			end
			sh_shr: begin
				// carry lands below the lsb
				wide = {a, 1'b0} >> shamt;
				result = wide[`EX_DATA_W:1];
				flags[`EX_CF] = wide[0];
			end
			sh_sar: begin
				wide = $signed({a, 1'b0}) >>> shamt;
				result = wide[`EX_DATA_W:1];
				flags[`EX_CF] = wide[0];
			end
			default: result = b;
		endcase
		// xchg leaves every flag clear
		if (op != sh_xchg) begin
			flags[`EX_ZF] = (result == '0);
			flags[`EX_SF] = result[`EX_DATA_W-1];
		end
	end

endmodule

// ==== source/ex_alu.sv ====
/*
 * EX ALU
 * 32-bit add/sub/logic with ZF SF CF OF, plus the MM packed adder
 * (four 16-bit lanes, no carry between lanes)
 */
`timescale 1ns/100ps

module ex_alu
	import ex_types_pkg::*;
(
	input alu_op_e op,
	input word_t a,
	input word_t b,
	input mm_t mm_a,
	input mm_t mm_b,
	output word_t result,
	output flags_t flags,
	output mm_t mm_result
);

	localparam int msb = `EX_DATA_W - 1;
	localparam int lane_w = `EX_MM_W / 4;

	logic [`EX_DATA_W:0] sum;
	logic cf;
	logic of;

	// ------------------------------
	// 32-bit operation
	// ------------------------------
	always_comb begin
		sum = '0;
		cf = 1'b0;
		of = 1'b0;
		result = '0;
		case (op)
			alu_add: begin
				sum = {1'b0, a} + {1'b0, b};
				result = sum[msb:0];
				cf = sum[`EX_DATA_W];
				// same sign in, other sign out
				of = (a[msb] == b[msb]) && (result[msb] != a[msb]);
			end
			alu_sub: begin
				sum = {1'b0, a} - {1'b0, b};
				result = sum[msb:0];
				// borrow out of the top
				cf = sum[`EX_DATA_W];
				of = (a[msb] != b[msb]) && (result[msb] != a[msb]);
			end
			alu_and: result = a & b;
			alu_or: result = a | b;
			alu_xor: result = a ^ b;
			alu_pass_b: result = b;
			default: result = '0;
		endcase
	end

	// flags word, unused bits stay clear
	always_comb begin
		flags = '0;
		flags[`EX_ZF] = (result == '0);
		flags[`EX_SF] = result[msb];
		flags[`EX_CF] = cf;
		flags[`EX_OF] = of;
	end

	// ------------------------------
	// MM packed add
	// ------------------------------
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			mm_result[i*lane_w +: lane_w] = mm_a[i*lane_w +: lane_w] + mm_b[i*lane_w +: lane_w];
		end
	end

endmodule

// ==== source/ex_operand_sel.sv ====
/*
 * EX operand select
 * holds A of the first CMPS micro-op and swaps it in as B on the second
 */
`timescale 1ns/100ps

module ex_operand_sel
	import ex_types_pkg::*;
	import ex_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic ex_v,
	input ex_ctrl_t ctrl,
	input word_t a,
	input word_t b,
	output word_t eff_b
);

	word_t cmps_tmp;

	// cmps temp, only a valid first uop loads it
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cmps_tmp <= '0;
		end else if (ex_v && ctrl.is_cmps_first) begin
			cmps_tmp <= a;
		end
	end

	// second uop compares against the held value
	assign eff_b = ctrl.is_cmps_second ? cmps_tmp : b;

	// a valid uop is one half of CMPS at most
	a_cmps_onehot : assert property (@(posedge clk) disable iff (!rst_n)
		ex_v |-> !(ctrl.is_cmps_first && ctrl.is_cmps_second));

endmodule

// ==== source/ex_ctrl_pkg.sv ====
/*
 * execute stage bundles
 * control word from decode, operands, and the EX/WB write-back record
 */
package ex_ctrl_pkg;
	import ex_types_pkg::*;

	// control bundle of the micro-op in EX
	typedef struct packed {
		alu_op_e alu_op;
		shift_op_e shift_op;
		// function unit select, 1 picks the shifter
		logic use_shift;
		logic pass_a;
		logic is_cmps_first;
		logic is_cmps_second;
		logic is_xchg;
		logic is_cmpxchg;
		logic sp_pop;
		dsize_t dsize;
		// write requests from decode
		logic ld_gpr1;
		logic ld_gpr2;
		logic ld_gpr3;
		logic ld_seg;
		logic ld_mm;
		logic dcache_write;
	} ex_ctrl_t;

	// operands read in decode
	typedef struct packed {
		word_t a;
		word_t b;
		word_t c;
		mm_t mm_a;
		mm_t mm_b;
	} ex_opnd_t;

	// write-back record, enables already qualified
	typedef struct packed {
		word_t result_a;
		word_t result_b;
		word_t result_c;
		flags_t flags;
		mm_t result_mm;
		logic ld_gpr1;
		logic ld_gpr2;
		logic ld_gpr3;
		logic ld_seg;
		logic ld_mm;
		logic dcache_write;
	} ex_wb_t;

endpackage

// ==== source/ex_types_pkg.sv ====
/*
 * execute stage data types
 * data path vectors and the ALU / shifter operation codes
 */
`include "ex_consts.svh"

package ex_types_pkg;

	// ------------------------------
	// data path vectors
	// ------------------------------
	typedef logic [`EX_DATA_W-1:0] word_t;
	typedef logic [`EX_DATA_W-1:0] flags_t;
	typedef logic [`EX_MM_W-1:0] mm_t;

	// bit 1 set means a 32-bit operand size
	typedef logic [1:0] dsize_t;

	// ------------------------------
	// function unit operations
	// ------------------------------
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b
	} alu_op_e;

	typedef enum logic [1:0] {
		sh_shl,
		sh_shr,
		sh_sar,
		sh_xchg
	} shift_op_e;

endpackage

// ==== include/ex_consts.svh ====
/*
 * execute stage constants
 * data widths, flag bit positions in the flags word, stack pop increments
 */
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// data path widths
`define EX_DATA_W 32
`define EX_MM_W 64

// flag positions, x86 eflags layout
`define EX_CF 0
`define EX_ZF 6
`define EX_SF 7
`define EX_OF 11

// esp increment on pop, word and dword
`define EX_POP_INC_W 2
`define EX_POP_INC_D 4

`endif
